/* verilog/cdc_consts.svh */
// cdc constants for payload widths and synchronizer depth
`ifndef CDC_CONSTS_SVH
`define CDC_CONSTS_SVH

//////////////////////////////
// payload widths

`define CFG_WORD_W  16 // config word, slow to fast
`define STAT_WORD_W 16 // status word, fast to slow

//////////////////////////////
// synchronizer depth

`define SYNC_STAGES 2  // toggle sync and reset re-timing

`endif

/* verilog/cdc_types_pkg.sv */
// cdc control types shared by the source side and the channel wrapper
package cdc_types_pkg;

  //////////////////////////////
  // source side handshake FSM

  typedef enum logic [1:0] {
    st_idle     = 2'd0, // free, src_ready high
    st_wait_ack = 2'd1, // word held, req flipped
    st_drain    = 2'd2  // ack seen, one settle cycle
  } src_state_e;

  //////////////////////////////
  // toggle pair of one channel

  // each bit flips once per word, never a level to be sampled as data
  typedef struct packed {
    logic req; // source to destination
    logic ack; // destination to source
  } xfer_ctrl_t;

endpackage

/* verilog/cfg_reg_pkg.sv */
// config and status payload types carried across the clock domains
`include "cdc_consts.svh"

package cfg_reg_pkg;

  //////////////////////////////
  // config opcodes

  typedef enum logic [3:0] {
    op_nop        = 4'h0, // no effect downstream
    op_set_gain   = 4'h1,
    op_set_offset = 4'h2,
    op_set_mode   = 4'h3,
    op_arm        = 4'h4  // start capture
  } cfg_op_e;

  //////////////////////////////
  // word layouts

  typedef struct packed {
    cfg_op_e                op;      // what to do
    logic [3:0]             channel; // target sample channel
    logic [`CFG_WORD_W-9:0] value;   // opcode argument
  } cfg_word_t;

  typedef struct packed {
    logic [3:0]              channel; // reporting channel
    logic [3:0]              flags;   // overflow, armed etc
    logic [`STAT_WORD_W-9:0] level;   // last measured level
  } stat_word_t;

endpackage

/* verilog/toggle_sync.sv */
// toggle synchronizer bringing one toggle bit in and pulsing on each change
`timescale 1ns/1ps
`include "cdc_consts.svh"

module toggle_sync #(
  parameter int STAGES = `SYNC_STAGES
) (
  input  logic in_toggle, // from the other clock domain
  input  logic clk,
  input  logic reset,
  output logic out_level,
  output logic change
);

  logic [STAGES-1:0] sync_q; // [0] may go metastable
  logic              last_q; // previous synchronized level

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q <= '0;
      last_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[STAGES-2:0], in_toggle};
      last_q <= sync_q[STAGES-1];
    end
  end

  assign out_level = sync_q[STAGES-1];
  assign change    = sync_q[STAGES-1] ^ last_q; // one cycle per flip

endmodule

/* verilog/cdc_src_side.sv */
// cdc source side FSM that holds one word and hands it over with a req toggle
`timescale 1ns/1ps
`include "cdc_consts.svh"

module cdc_src_side
  import cdc_types_pkg::*;
#(
  parameter int DWIDTH = `CFG_WORD_W
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [DWIDTH-1:0] src_data,
  input  logic              src_valid,
  output logic              src_ready,
  output logic [DWIDTH-1:0] held_data,
  output logic              req,
  input  logic              ack_change // already synchronized
);

  src_state_e        state_q;
  src_state_e        state_d;
  logic              req_q;
  logic [DWIDTH-1:0] held_q;
  logic              accept;

  assign src_ready = (state_q == st_idle);
  assign accept    = src_valid & src_ready;

  //////////////////////////////
  // next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (src_valid) begin
          state_d = st_wait_ack; // word taken this edge
        end
      end
      st_wait_ack: begin
        if (ack_change) begin
          state_d = st_drain;
        end
      end
      st_drain: begin
        state_d = st_idle; // ack pulse gone by now
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  //////////////////////////////
  // state and req toggle

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        req_q <= ~req_q; // announce new word
      end
    end
  end

  // payload stays put until the ack returns
  always_ff @(posedge clk) begin
    if (accept) begin
      held_q <= src_data;
    end
  end

  assign held_data = held_q;
  assign req       = req_q;

endmodule

/* verilog/cdc_dest_side.sv */
// cdc destination side that presents the crossed word and returns an ack toggle
`timescale 1ns/1ps
`include "cdc_consts.svh"

module cdc_dest_side #(
  parameter int DWIDTH = `CFG_WORD_W
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [DWIDTH-1:0] held_data, // stable while req is in flight
  input  logic              req_change,
  output logic [DWIDTH-1:0] dest_data,
  output logic              dest_valid,
  input  logic              dest_ready,
  output logic              ack
);

  logic [DWIDTH-1:0] data_q;
  logic              valid_q;
  logic              ack_q;
  logic              take;

  assign take = valid_q & dest_ready; // consumer handshake

  //////////////////////////////
  // valid and ack toggle

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      if (take) begin
        valid_q <= 1'b0;
        ack_q   <= ~ack_q; // frees the source
      end else if (req_change) begin
        valid_q <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // output word

  // no new req can arrive before the ack, so the capture never
  // overwrites a word still waiting for the consumer
  always_ff @(posedge clk) begin
    if (req_change) begin
      data_q <= held_data;
    end
  end

  assign dest_data  = data_q;
  assign dest_valid = valid_q;
  assign ack        = ack_q;

endmodule

/* verilog/axis_config_reg_cdc.sv */
// one register-style crossing channel with req/ack toggles and reset re-timing
`timescale 1ns/1ps
`include "cdc_consts.svh"

module axis_config_reg_cdc
  import cdc_types_pkg::*;
#(
  parameter int DWIDTH = `CFG_WORD_W
) (
  input  logic              src_clk,
  input  logic              dest_clk,
  input  logic              reset,
  input  logic [DWIDTH-1:0] src_data,
  input  logic              src_valid,
  output logic              src_ready,
  output logic [DWIDTH-1:0] dest_data,
  output logic              dest_valid,
  input  logic              dest_ready
);

  xfer_ctrl_t              xfer;          // req and ack toggles
  logic [DWIDTH-1:0]       held_data;     // crosses unsynchronized
  logic                    req_change;    // dest domain
  logic                    ack_change;    // src domain
  logic [`SYNC_STAGES-1:0] src_rst_q;
  logic [`SYNC_STAGES-1:0] dest_rst_q;
  logic                    src_reset;
  logic                    dest_reset;

  //////////////////////////////
  // reset re-timing

  // the one system reset may belong to either side's clock, so each side
  // takes its own copy through a short flop chain
  always_ff @(posedge src_clk) begin
    src_rst_q <= {src_rst_q[`SYNC_STAGES-2:0], reset};
  end

  always_ff @(posedge dest_clk) begin
    dest_rst_q <= {dest_rst_q[`SYNC_STAGES-2:0], reset};
  end

  assign src_reset  = src_rst_q[`SYNC_STAGES-1];
  assign dest_reset = dest_rst_q[`SYNC_STAGES-1];

  //////////////////////////////
  // channel halves

  cdc_src_side #(
    .DWIDTH(DWIDTH)
  ) u_src (
    .clk       (src_clk),
    .reset     (src_reset),
    .src_data  (src_data),
    .src_valid (src_valid),
    .src_ready (src_ready),
    .held_data (held_data),
    .req       (xfer.req),
    .ack_change(ack_change)
  );

  toggle_sync u_req_sync (
    .in_toggle(xfer.req),
    .clk      (dest_clk),
    .reset    (dest_reset),
    .out_level(),           // only the edge matters
    .change   (req_change)
  );

  cdc_dest_side #(
    .DWIDTH(DWIDTH)
  ) u_dest (
    .clk       (dest_clk),
    .reset     (dest_reset),
    .held_data (held_data),
    .req_change(req_change),
    .dest_data (dest_data),
    .dest_valid(dest_valid),
    .dest_ready(dest_ready),
    .ack       (xfer.ack)
  );

  toggle_sync u_ack_sync (
    .in_toggle(xfer.ack),
    .clk      (src_clk),
    .reset    (src_reset),
    .out_level(),
    .change   (ack_change)
  );

endmodule

/* verilog/config_cdc_top.sv */
// config and status crossing top with one channel per direction
`timescale 1ns/1ps
`include "cdc_consts.svh"

module config_cdc_top
  import cfg_reg_pkg::*;
(
  input  logic       slow_clk,
  input  logic       fast_clk,
  input  logic       fast_reset,     // slow_clk domain
  // downstream, slow to fast
  input  cfg_word_t  cfg_in,
  input  logic       cfg_in_valid,
  output logic       cfg_in_ready,
  output cfg_word_t  cfg_out,
  output logic       cfg_out_valid,
  input  logic       cfg_out_ready,
  // upstream, fast to slow
  input  stat_word_t stat_in,
  input  logic       stat_in_valid,
  output logic       stat_in_ready,
  output stat_word_t stat_out,
  output logic       stat_out_valid,
  input  logic       stat_out_ready
);

  logic [`CFG_WORD_W-1:0]  cfg_out_bus;
  logic [`STAT_WORD_W-1:0] stat_out_bus;

  //////////////////////////////
  // config words to the sample domain

  axis_config_reg_cdc #(
    .DWIDTH($bits(cfg_word_t))
  ) u_cfg_down (
    .src_clk   (slow_clk),
    .dest_clk  (fast_clk),
    .reset     (fast_reset),
    .src_data  (cfg_in),
    .src_valid (cfg_in_valid),
    .src_ready (cfg_in_ready),
    .dest_data (cfg_out_bus),
    .dest_valid(cfg_out_valid),
    .dest_ready(cfg_out_ready)
  );

  //////////////////////////////
  // status words back to control

  axis_config_reg_cdc #(
    .DWIDTH($bits(stat_word_t))
  ) u_stat_up (
    .src_clk   (fast_clk),
    .dest_clk  (slow_clk),
    .reset     (fast_reset),
    .src_data  (stat_in),
    .src_valid (stat_in_valid),
    .src_ready (stat_in_ready),
    .dest_data (stat_out_bus),
    .dest_valid(stat_out_valid),
    .dest_ready(stat_out_ready)
  );

  assign cfg_out  = cfg_word_t'(cfg_out_bus);
  assign stat_out = stat_word_t'(stat_out_bus);

endmodule

/* testbench/config_cdc_tb.sv */
// testbench for the config and status crossing top, table driven with random back-pressure
`timescale 1ns/1ps

module config_cdc_tb
  import cfg_reg_pkg::*;
;

  localparam int N = 16; // table entries

  logic       slow_clk;
  logic       fast_clk;
  logic       fast_reset;
  cfg_word_t  cfg_in;
  logic       cfg_in_valid;
  logic       cfg_in_ready;
  cfg_word_t  cfg_out;
  logic       cfg_out_valid;
  logic       cfg_out_ready;
  stat_word_t stat_in;
  logic       stat_in_valid;
  logic       stat_in_ready;
  stat_word_t stat_out;
  logic       stat_out_valid;
  logic       stat_out_ready;

  cfg_word_t  cfg_tbl  [N];
  stat_word_t stat_tbl [N];
  logic       bp_cfg   [N]; // gaps on the downstream channel
  logic       bp_stat  [N];

  int   err_count;
  int   ok_count;
  int   cfg_sent;
  int   cfg_taken;
  int   stat_sent;
  int   stat_taken;
  logic start;
  logic cfg_done;
  logic stat_done;

  config_cdc_top u_dut (
    .slow_clk      (slow_clk),
    .fast_clk      (fast_clk),
    .fast_reset    (fast_reset),
    .cfg_in        (cfg_in),
    .cfg_in_valid  (cfg_in_valid),
    .cfg_in_ready  (cfg_in_ready),
    .cfg_out       (cfg_out),
    .cfg_out_valid (cfg_out_valid),
    .cfg_out_ready (cfg_out_ready),
    .stat_in       (stat_in),
    .stat_in_valid (stat_in_valid),
    .stat_in_ready (stat_in_ready),
    .stat_out      (stat_out),
    .stat_out_valid(stat_out_valid),
    .stat_out_ready(stat_out_ready)
  );

  initial begin
    slow_clk = 1'b0;
    forever #10 slow_clk = ~slow_clk;
  end

  initial begin
    fast_clk = 1'b0;
    forever #3.5 fast_clk = ~fast_clk;
  end

  //////////////////////////////
  // helpers

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0); // galois taps
  endfunction

  task automatic check_cfg(input cfg_word_t got, input cfg_word_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_stat(input stat_word_t got, input stat_word_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  //////////////////////////////
  // producers

  initial begin : cfg_source
    logic [31:0] lf;
    int          gap;
    logic        acc;
    lf = 32'he25f;
    wait (start);
    for (int i = 0; i < N; i++) begin
      gap = 0;
      if (bp_cfg[i]) begin
        gap = {lf[0], 1'b0};
        lf  = lfsr_next(lf);
        gap = gap | int'(lf[0]);
        lf  = lfsr_next(lf);
      end
      repeat (gap) begin
        @(posedge slow_clk);
        #2;
      end
      cfg_in       = cfg_tbl[i];
      cfg_in_valid = 1'b1;
      acc          = 1'b0;
      while (!acc) begin
        acc = cfg_in_ready;
        if (acc && cfg_sent != cfg_taken) begin
          $display("[FAIL] %0t ns cfg_in_ready high while a word is pending", $time);
          err_count++;
        end
        @(posedge slow_clk);
        #2;
      end
      cfg_sent++;
      cfg_in_valid = 1'b0;
    end
  end

  initial begin : stat_source
    logic [31:0] lf;
    int          gap;
    logic        acc;
    lf = 32'he25f;
    wait (start);
    @(posedge fast_clk); // line up with the fast domain
    #2;
    for (int i = 0; i < N; i++) begin
      gap = 0;
      if (bp_stat[i]) begin
        gap = {lf[0], 1'b0};
        lf  = lfsr_next(lf);
        gap = gap | int'(lf[0]);
        lf  = lfsr_next(lf);
      end
      repeat (gap) begin
        @(posedge fast_clk);
        #2;
      end
      stat_in       = stat_tbl[i];
      stat_in_valid = 1'b1;
      acc           = 1'b0;
      while (!acc) begin
        acc = stat_in_ready;
        if (acc && stat_sent != stat_taken) begin
          $display("[FAIL] %0t ns stat_in_ready high while a word is pending", $time);
          err_count++;
        end
        @(posedge fast_clk);
        #2;
      end
      stat_sent++;
      stat_in_valid = 1'b0;
    end
  end

  //////////////////////////////
  // consumers

  initial begin : cfg_sink
    logic [31:0] lf;
    logic        stalled;
    cfg_word_t   last;
    int          idx;
    lf      = 32'h0000_e25f;
    stalled = 1'b0;
    last    = '0;
    idx     = 0;
    wait (start);
    while (idx < N) begin
      @(posedge fast_clk);
      #2;
      if (stalled) begin // valid was high, ready low
        check_bit(cfg_out_valid, 1'b1, "cfg_out_valid dropped under back-pressure");
        check_cfg(cfg_out, last, "cfg_out changed under back-pressure");
      end
      if (bp_cfg[idx]) begin
        cfg_out_ready = lf[0];
        lf            = lfsr_next(lf);
      end else begin
        cfg_out_ready = 1'b1;
      end
      if (cfg_out_valid && cfg_out_ready) begin
        check_cfg(cfg_out, cfg_tbl[idx], $sformatf("cfg word %0d", idx));
        $display("test cfg %0d done, word %h op %s", idx, cfg_out, cfg_out.op.name());
        ok_count++;
        cfg_taken++;
        idx++;
        stalled = 1'b0;
      end else begin
        stalled = cfg_out_valid;
        last    = cfg_out;
      end
    end
    @(posedge fast_clk);
    #2;
    cfg_out_ready = 1'b0; // a stray extra word now stays visible
    cfg_done      = 1'b1;
  end

  initial begin : stat_sink
    logic [31:0] lf;
    logic        stalled;
    stat_word_t  last;
    int          idx;
    lf      = 32'he25f;
    stalled = 1'b0;
    last    = '0;
    idx     = 0;
    wait (start);
    while (idx < N) begin
      @(posedge slow_clk);
      #2;
      if (stalled) begin
        check_bit(stat_out_valid, 1'b1, "stat_out_valid dropped under back-pressure");
        check_stat(stat_out, last, "stat_out changed under back-pressure");
      end
      if (bp_stat[idx]) begin
        stat_out_ready = lf[0];
        lf             = lfsr_next(lf);
      end else begin
        stat_out_ready = 1'b1;
      end
      if (stat_out_valid && stat_out_ready) begin
        check_stat(stat_out, stat_tbl[idx], $sformatf("stat word %0d", idx));
        $display("test stat %0d done, word %h", idx, stat_out);
        ok_count++;
        stat_taken++;
        idx++;
        stalled = 1'b0;
      end else begin
        stalled = stat_out_valid;
        last    = stat_out;
      end
    end
    @(posedge slow_clk);
    #2;
    stat_out_ready = 1'b0;
    stat_done      = 1'b1;
  end

  //////////////////////////////
  // main sequence

  initial begin : main_seq
    fast_reset     = 1'b1;
    cfg_in         = '0;
    cfg_in_valid   = 1'b0;
    cfg_out_ready  = 1'b0;
    stat_in        = '0;
    stat_in_valid  = 1'b0;
    stat_out_ready = 1'b0;
    err_count      = 0;
    ok_count       = 0;
    cfg_sent       = 0;
    cfg_taken      = 0;
    stat_sent      = 0;
    stat_taken     = 0;
    start          = 1'b0;
    cfg_done       = 1'b0;
    stat_done      = 1'b0;
    for (int i = 0; i < N; i++) begin
      cfg_tbl[i].op      = cfg_op_e'(i % 5); // every opcode shows up
      cfg_tbl[i].channel = 4'(i);
      cfg_tbl[i].value   = 8'(i * 37 + 5);
      stat_tbl[i].channel = 4'(15 - i);
      stat_tbl[i].flags   = 4'(i * 3);
      stat_tbl[i].level   = 8'(i * 19 + 200);
      bp_cfg[i]  = (i >= 6);        // first entries run with ready high
      bp_stat[i] = (i >= 6) && (i % 3 != 0);
    end
    repeat (5) @(posedge slow_clk);
    #2;
    fast_reset = 1'b0;
    repeat (4) @(posedge slow_clk);
    #2;
    check_bit(cfg_in_ready, 1'b1, "cfg_in_ready after reset");
    check_bit(stat_in_ready, 1'b1, "stat_in_ready after reset");
    check_bit(cfg_out_valid, 1'b0, "cfg_out_valid after reset");
    check_bit(stat_out_valid, 1'b0, "stat_out_valid after reset");
    $display("test reset state done");
    start = 1'b1;
    wait (cfg_done && stat_done);
    repeat (20) @(posedge slow_clk);
    #2;
    if (cfg_out_valid || stat_out_valid) begin
      $display("an extra word showed up after the whole table was received");
      err_count++;
    end
    if (cfg_taken != N || stat_taken != N) begin
      $display("words missing at the end: cfg %0d of %0d, stat %0d of %0d",
               cfg_taken, N, stat_taken, N);
      err_count++;
    end
    $display("words checked %0d, errors %0d", ok_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(N * 200 * 20);
    $display("watchdog expired before all words crossed");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+verilog
verilog/cdc_types_pkg.sv
verilog/cfg_reg_pkg.sv
verilog/toggle_sync.sv
verilog/cdc_src_side.sv
verilog/cdc_dest_side.sv
verilog/axis_config_reg_cdc.sv
verilog/config_cdc_top.sv
testbench/config_cdc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the crossing testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -j 0 \
  -f vlog.f \
  --top-module config_cdc_tb \
  -o config_cdc_sim \
  && ./obj_dir/config_cdc_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
